/* files.f */
source/lidar_pkg.sv
source/tdc_spi_master.sv
source/tdc_control.sv
source/sample_fifo.sv
source/uart_packer.sv
source/lidar_top.sv
tb/lidar_sva.sv
tb/lidar_monitor.sv
tb/tb_lidar_top.sv

/* run.sh */
#!/bin/sh
# build the lidar channel testbench with Verilator, run it, judge from the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_lidar_top -f files.f \
  && ./obj_dir/Vtb_lidar_top +verilator+error+limit+1000 > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation aborted"; exit 1; }
cat sim.log
grep -q "Test FAILED" sim.log && exit 1 || exit 0

/* source/lidar_pkg.sv */
`default_nettype none

package lidar_pkg;

  // time-of-flight count from the TDC result register
  typedef logic [23:0] tdc_result_t;

  // per-shot tag, wraps at 256
  typedef logic [7:0] shot_seq_t;

  // one full SPI transfer, opcode in the top byte
  typedef logic [31:0] spi_word_t;

  // tdc read command, first byte on mosi
  localparam logic [7:0] TDC_READ_OP = 8'h90;

  // bytes per uart frame, one per byte of a fifo entry
  localparam int FRAME_BYTES = 4;

  // producer view: seq on top, result below
  typedef struct packed {
    shot_seq_t   seq;
    tdc_result_t result;
  } sample_fields_t;

  // same 32 bits, seen as fields or as bytes
  // byte 3 is the seq byte and goes out first
  typedef union packed {
    sample_fields_t                 f;
    logic [FRAME_BYTES-1:0][7:0] b;
  } sample_entry_t;

endpackage

`default_nettype wire

/* source/lidar_top.sv */
`default_nettype none

module lidar_top #(
  // about 14 kHz shots at 50 MHz
  parameter int SHOT_PERIOD = 3571,
  // sck half period in clk cycles
  parameter int SPI_DIV     = 4,
  // roughly 4 Mbaud
  parameter int BAUD_DIV    = 12,
  // 64 entries
  parameter int FIFO_AW     = 6
) (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  pause,
  input  wire  tdc_intb,
  input  wire  tdc_dout,
  output logic tdc_start_signal,
  output logic tdc_cs,
  output logic tdc_sck,
  output logic tdc_mosi,
  output logic serial_out
);

  // control to spi
  logic                     spi_start;
  logic                     spi_done;
  lidar_pkg::spi_word_t     spi_wdata;
  lidar_pkg::spi_word_t     spi_rdata;
  // control to fifo
  logic                     wr_en;
  lidar_pkg::sample_entry_t wr_entry;
  // fifo to uart
  logic                     rd_en;
  logic                     rd_valid;
  lidar_pkg::sample_entry_t rd_entry;
  // uart back to control
  logic                     credit_return;

  tdc_control #(
    .SHOT_PERIOD(SHOT_PERIOD),
    .FIFO_AW(FIFO_AW)
  ) tdc_control (
    .clk(clk),
    .rst_n(rst_n),
    .pause(pause),
    .tdc_intb(tdc_intb),
    .spi_done(spi_done),
    .spi_rdata(spi_rdata),
    .credit_return(credit_return),
    .tdc_start_signal(tdc_start_signal),
    .spi_start(spi_start),
    .spi_wdata(spi_wdata),
    .wr_en(wr_en),
    .wr_entry(wr_entry)
  );

  tdc_spi_master #(
    .SPI_DIV(SPI_DIV)
  ) tdc_spi_master (
    .clk(clk),
    .rst_n(rst_n),
    .spi_start(spi_start),
    .spi_wdata(spi_wdata),
    .tdc_dout(tdc_dout),
    .tdc_cs(tdc_cs),
    .tdc_sck(tdc_sck),
    .tdc_mosi(tdc_mosi),
    .spi_done(spi_done),
    .spi_rdata(spi_rdata)
  );

  sample_fifo #(
    .FIFO_AW(FIFO_AW)
  ) sample_fifo (
    .clk(clk),
    .rst_n(rst_n),
    .wr_en(wr_en),
    .wr_entry(wr_entry),
    .rd_en(rd_en),
    .rd_valid(rd_valid),
    .rd_entry(rd_entry)
  );

  uart_packer #(
    .BAUD_DIV(BAUD_DIV)
  ) uart_packer (
    .clk(clk),
    .rst_n(rst_n),
    .rd_valid(rd_valid),
    .rd_entry(rd_entry),
    .rd_en(rd_en),
    .credit_return(credit_return),
    .serial_out(serial_out)
  );

endmodule

`default_nettype wire

/* source/sample_fifo.sv */
`default_nettype none

module sample_fifo #(
  parameter int FIFO_AW = 6
) (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          wr_en,
  input  wire lidar_pkg::sample_entry_t wr_entry,
  input  wire                          rd_en,
  output logic                         rd_valid,
  output lidar_pkg::sample_entry_t     rd_entry
);

  localparam int DEPTH = 2 ** FIFO_AW;

  lidar_pkg::sample_entry_t mem [DEPTH];
  // extra msb tells full from empty
  logic [FIFO_AW:0]         wr_ptr;
  logic [FIFO_AW:0]         rd_ptr;

  // not empty
  assign rd_valid = (wr_ptr != rd_ptr);
  // fall-through, head entry always visible
  assign rd_entry = mem[rd_ptr[FIFO_AW-1:0]];

  // no full check here, writer is credit limited
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en && rd_valid) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr[FIFO_AW-1:0]] <= wr_entry;
    end
  end

endmodule

`default_nettype wire

/* source/tdc_control.sv */
`default_nettype none

module tdc_control #(
  parameter int SHOT_PERIOD = 3571,
  parameter int FIFO_AW     = 6
) (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      pause,
  input  wire                      tdc_intb,
  input  wire                      spi_done,
  input  wire lidar_pkg::spi_word_t spi_rdata,
  input  wire                      credit_return,
  output logic                     tdc_start_signal,
  output logic                     spi_start,
  output lidar_pkg::spi_word_t     spi_wdata,
  output logic                     wr_en,
  output lidar_pkg::sample_entry_t wr_entry
);

  localparam int SW = (SHOT_PERIOD > 1) ? $clog2(SHOT_PERIOD) : 1;
  // credits run 0 to depth and need one bit more than the address
  localparam int CW = FIFO_AW + 1;
  localparam logic [CW-1:0] DEPTH = CW'(2 ** FIFO_AW);

  // fsm states
  localparam logic [1:0] ST_TIMING   = 2'd0;
  localparam logic [1:0] ST_FIRE     = 2'd1;
  localparam logic [1:0] ST_WAIT_INT = 2'd2;
  localparam logic [1:0] ST_READ     = 2'd3;

  logic [1:0]           state;
  logic [SW-1:0]        shot_cnt;
  logic                 shot_due;
  logic                 can_fire;
  lidar_pkg::shot_seq_t seq;
  logic [CW-1:0]        credits;
  // intb comes from the tdc clock domain
  logic [1:0]           intb_sync;

  // read opcode with don't-care low bits
  assign spi_wdata = {lidar_pkg::TDC_READ_OP, 24'd0};

  assign shot_due = (shot_cnt == SW'(SHOT_PERIOD - 1));
  // a write in flight still owns the last credit
  assign can_fire = (credits != '0) && !wr_en;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state            <= ST_TIMING;
      shot_cnt         <= '0;
      seq              <= '0;
      intb_sync        <= 2'b11;
      tdc_start_signal <= 1'b0;
      spi_start        <= 1'b0;
      wr_en            <= 1'b0;
    end else begin
      intb_sync        <= {intb_sync[0], tdc_intb};
      // single-cycle pulses by default
      tdc_start_signal <= 1'b0;
      spi_start        <= 1'b0;
      wr_en            <= 1'b0;
      // shot timer runs through the read and freezes while paused
      if (!pause && !shot_due) begin
        shot_cnt <= shot_cnt + 1'b1;
      end
      case (state)
        ST_TIMING: begin
          // held at expiry until a credit comes back
          if (!pause && shot_due && can_fire) begin
            shot_cnt         <= '0;
            tdc_start_signal <= 1'b1;
            state            <= ST_FIRE;
          end
        end
        // start pulse is high in this state only
        ST_FIRE: state <= ST_WAIT_INT;
        ST_WAIT_INT: begin
          // intb low means result ready
          if (!intb_sync[1]) begin
            spi_start <= 1'b1;
            state     <= ST_READ;
          end
        end
        ST_READ: begin
          if (spi_done) begin
            wr_en <= 1'b1;
            seq   <= seq + 1'b1;
            state <= ST_TIMING;
          end
        end
        default: state <= ST_TIMING;
      endcase
    end
  end

  // entry built from current seq and low 24 result bits
  always_ff @(posedge clk) begin
    if (state == ST_READ && spi_done) begin
      wr_entry.f.seq    <= seq;
      wr_entry.f.result <= spi_rdata[23:0];
    end
  end

  // a write takes a credit and a pop gives one back
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits <= DEPTH;
    end else begin
      case ({wr_en, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/tdc_spi_master.sv */
`default_nettype none

module tdc_spi_master #(
  parameter int SPI_DIV = 4
) (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   spi_start,
  input  wire lidar_pkg::spi_word_t spi_wdata,
  input  wire                   tdc_dout,
  output logic                  tdc_cs,
  output logic                  tdc_sck,
  output logic                  tdc_mosi,
  output logic                  spi_done,
  output lidar_pkg::spi_word_t  spi_rdata
);

  // divider width, at least one bit
  localparam int DW = (SPI_DIV > 1) ? $clog2(SPI_DIV) : 1;

  logic [DW-1:0]        div_cnt;
  // 64 half periods per 32-bit transfer
  logic [5:0]           half_cnt;
  logic                 half_tick;
  lidar_pkg::spi_word_t tx_sr;
  lidar_pkg::spi_word_t rx_sr;

  assign half_tick = (div_cnt == DW'(SPI_DIV - 1));

  // msb first, bit 31 always on the wire
  assign tdc_mosi  = tx_sr[31];
  // last 32 sampled bits, stable after done
  assign spi_rdata = rx_sr;

  // cs low doubles as the busy flag
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tdc_cs   <= 1'b1;
      tdc_sck  <= 1'b0;
      spi_done <= 1'b0;
      div_cnt  <= '0;
      half_cnt <= '0;
    end else begin
      spi_done <= 1'b0;
      if (tdc_cs) begin
        if (spi_start) begin
          tdc_cs   <= 1'b0;
          div_cnt  <= '0;
          half_cnt <= '0;
        end
      end else if (half_tick) begin
        div_cnt  <= '0;
        half_cnt <= half_cnt + 1'b1;
        tdc_sck  <= ~tdc_sck;
        // last falling edge, release cs with it
        if (half_cnt == 6'd63) begin
          tdc_cs   <= 1'b1;
          spi_done <= 1'b1;
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // shift registers
  always_ff @(posedge clk) begin
    if (tdc_cs && spi_start) begin
      tx_sr <= spi_wdata;
    end else if (!tdc_cs && half_tick) begin
      if (tdc_sck) begin
        // falling sck, next mosi bit
        tx_sr <= {tx_sr[30:0], 1'b0};
      end else begin
        // rising sck, sample miso
        rx_sr <= {rx_sr[30:0], tdc_dout};
      end
    end
  end

endmodule

`default_nettype wire

/* source/uart_packer.sv */
`default_nettype none

module uart_packer #(
  parameter int BAUD_DIV = 12
) (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          rd_valid,
  input  wire lidar_pkg::sample_entry_t rd_entry,
  output logic                         rd_en,
  output logic                         credit_return,
  output logic                         serial_out
);

  localparam int BW = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
  localparam int IW = $clog2(lidar_pkg::FRAME_BYTES);

  logic                     busy;
  logic                     baud_tick;
  logic [BW-1:0]            baud_cnt;
  // 0 start, 1..8 data, 9 stop
  logic [3:0]               bit_cnt;
  logic [IW-1:0]            byte_idx;
  logic [IW-1:0]            next_idx;
  // stop, data, start; lsb on the line
  logic [9:0]               tx_sr;
  lidar_pkg::sample_entry_t frame;

  // pop only between frames
  assign rd_en         = rd_valid && !busy;
  // each pop frees one fifo slot
  assign credit_return = rd_en;

  assign baud_tick  = (baud_cnt == BW'(BAUD_DIV - 1));
  assign next_idx   = byte_idx - 1'b1;
  assign serial_out = tx_sr[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      byte_idx <= '0;
      // line idles high
      tx_sr    <= '1;
    end else if (rd_en) begin
      // seq byte first
      busy     <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      byte_idx <= IW'(lidar_pkg::FRAME_BYTES - 1);
      tx_sr    <= {1'b1, rd_entry.b[lidar_pkg::FRAME_BYTES-1], 1'b0};
    end else if (busy) begin
      if (!baud_tick) begin
        baud_cnt <= baud_cnt + 1'b1;
      end else begin
        baud_cnt <= '0;
        if (bit_cnt != 4'd9) begin
          bit_cnt <= bit_cnt + 1'b1;
          // ones shifted in, so the line is high after stop
          tx_sr   <= {1'b1, tx_sr[9:1]};
        end else begin
          bit_cnt <= '0;
          if (byte_idx == '0) begin
            busy <= 1'b0;
          end else begin
            // next char right after the stop bit
            byte_idx <= next_idx;
            tx_sr    <= {1'b1, frame.b[next_idx], 1'b0};
          end
        end
      end
    end
  end

  // popped entry, held for the lower bytes
  always_ff @(posedge clk) begin
    if (rd_en) begin
      frame <= rd_entry;
    end
  end

endmodule

`default_nettype wire

/* tb/lidar_monitor.sv */
`default_nettype none

module lidar_monitor #(
  parameter int BAUD_DIV   = 8,
  parameter int FIFO_DEPTH = 4,
  parameter int N_ROWS     = 16
) (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    pause,
  input  wire                    tdc_start_signal,
  input  wire                    tdc_cs,
  input  wire                    tdc_sck,
  input  wire                    tdc_mosi,
  input  wire                    serial_out,
  input  wire [N_ROWS-1:0][23:0] exp_results,
  output int                     shots,
  output int                     frames,
  output int                     errors
);

  // tdc read command on mosi
  localparam logic [7:0] READ_OP = 8'h90;

  logic       cs_q;
  logic       sck_q;
  logic       pause_q;
  logic       start_pending;
  int         spi_bits;
  logic [7:0] spi_op;
  logic       rx_busy;
  int         rx_cnt;
  int         rx_bit;
  logic [7:0] rx_byte;
  int         byte_cnt;
  // byte 0 is the seq byte
  logic [7:0] rx_frame [4];

  task automatic report_mismatch(input string msg);
    errors++;
    $display("CHECK FAILED at %0t: %s", $time, msg);
  endtask

  // four bytes make a frame
  task automatic take_byte(input logic [7:0] data);
    logic [23:0] got;
    rx_frame[byte_cnt] = data;
    byte_cnt++;
    if (byte_cnt == 4) begin
      byte_cnt = 0;
      got = {rx_frame[1], rx_frame[2], rx_frame[3]};
      if (frames >= N_ROWS) begin
        report_mismatch("frame received beyond the end of the table");
      end else begin
        if (rx_frame[0] != 8'(frames)) begin
          report_mismatch($sformatf("frame %0d seq %02h, expected %02h",
                                    frames, rx_frame[0], 8'(frames)));
        end
        if (got != exp_results[frames]) begin
          report_mismatch($sformatf("frame %0d result %06h, expected %06h",
                                    frames, got, exp_results[frames]));
        end
      end
      frames++;
    end
  endtask

  // 8N1 receiver, samples mid-bit
  task automatic uart_sample();
    if (!rx_busy) begin
      if (serial_out == 1'b0) begin
        rx_busy = 1'b1;
        rx_cnt  = 0;
        rx_bit  = 0;
      end
    end else begin
      rx_cnt++;
      if (rx_cnt == BAUD_DIV / 2 + rx_bit * BAUD_DIV) begin
        if (rx_bit == 0) begin
          if (serial_out != 1'b0) begin
            report_mismatch("uart start bit shorter than half a bit");
          end
        end else if (rx_bit <= 8) begin
          // lsb first
          rx_byte = {serial_out, rx_byte[7:1]};
        end else begin
          rx_busy = 1'b0;
          if (serial_out != 1'b1) begin
            report_mismatch("uart stop bit low");
          end else begin
            take_byte(rx_byte);
          end
        end
        rx_bit++;
      end
    end
  endtask

  // everything sampled mid-cycle
  always @(negedge clk) begin
    if (!rst_n) begin
      if (tdc_cs !== 1'b1 || serial_out !== 1'b1 ||
          tdc_start_signal !== 1'b0 || tdc_sck !== 1'b0) begin
        report_mismatch("outputs not at their reset values");
      end
      cs_q          = 1'b1;
      sck_q         = 1'b0;
      pause_q       = 1'b0;
      start_pending = 1'b0;
      rx_busy       = 1'b0;
      byte_cnt      = 0;
      shots         = 0;
      frames        = 0;
    end else begin
      // pause seen by the dut at the edge before
      if (tdc_start_signal && pause_q) begin
        report_mismatch("start pulse while pause is high");
      end
      if (tdc_start_signal) begin
        if (start_pending) begin
          report_mismatch("start pulse with no spi transfer after the previous one");
        end
        start_pending = 1'b1;
        shots++;
      end
      if (cs_q && !tdc_cs) begin
        if (!start_pending) begin
          report_mismatch("spi transfer without a start pulse");
        end
        start_pending = 1'b0;
        spi_bits      = 0;
        spi_op        = '0;
      end
      // mosi settled at the rising sck
      if (!tdc_cs && !sck_q && tdc_sck) begin
        if (spi_bits < 8) begin
          spi_op = {spi_op[6:0], tdc_mosi};
        end
        spi_bits++;
      end
      if (!cs_q && tdc_cs) begin
        if (spi_bits != 32) begin
          report_mismatch($sformatf("spi transfer of %0d bits, expected 32", spi_bits));
        end
        if (spi_op != READ_OP) begin
          report_mismatch($sformatf("spi opcode %02h, expected %02h", spi_op, READ_OP));
        end
      end
      uart_sample();
      // full fifo plus the shot in flight
      if (shots - frames > FIFO_DEPTH + 1) begin
        report_mismatch($sformatf("%0d shots ahead of the frames", shots - frames));
      end
      cs_q    = tdc_cs;
      sck_q   = tdc_sck;
      pause_q = pause;
    end
  end

endmodule

`default_nettype wire

/* tb/lidar_sva.sv */
`default_nettype none

module lidar_sva (
  input wire clk,
  input wire rst_n,
  input wire tdc_start_signal,
  input wire tdc_cs,
  input wire tdc_sck,
  input wire serial_out
);

  // read by the testbench at the end
  int failures;

  // single-cycle start pulse
  start_one_cycle: assert property (
    @(posedge clk) disable iff (!rst_n) tdc_start_signal |=> !tdc_start_signal
  ) else begin
    failures++;
    $error("tdc_start_signal high for more than one cycle");
  end

  // sck parked low when the tdc is deselected
  sck_low_when_idle: assert property (
    @(posedge clk) disable iff (!rst_n) tdc_cs |-> !tdc_sck
  ) else begin
    failures++;
    $error("tdc_sck high while tdc_cs is high");
  end

  // uart line idle during reset
  serial_idle_in_reset: assert property (
    @(posedge clk) !rst_n |-> serial_out
  ) else begin
    failures++;
    $error("serial_out low during reset");
  end

endmodule

`default_nettype wire

/* tb/tb_lidar_top.sv */
`default_nettype none

module tb_lidar_top;

  // mirrors the lidar_top values used here
  localparam int SHOT_PERIOD  = 200;
  localparam int SPI_DIV      = 2;
  localparam int BAUD_DIV     = 8;
  localparam int FIFO_AW      = 2;
  localparam int N_ROWS       = 16;
  localparam int PAUSE_CYCLES = 1000;

  // one stimulus row
  typedef struct packed {
    logic [23:0] result;
    logic [7:0]  delay;
    logic        pause;
  } stim_row_t;

  logic clk;
  logic rst_n;
  logic pause;
  logic tdc_intb;
  logic tdc_dout;
  logic tdc_start_signal;
  logic tdc_cs;
  logic tdc_sck;
  logic tdc_mosi;
  logic serial_out;

  stim_row_t               rows [N_ROWS];
  // expected results in frame order
  logic [N_ROWS-1:0][23:0] exp_results;
  int                      shots;
  int                      frames;
  int                      errors;

  lidar_top #(
    .SHOT_PERIOD(SHOT_PERIOD),
    .SPI_DIV(SPI_DIV),
    .BAUD_DIV(BAUD_DIV),
    .FIFO_AW(FIFO_AW)
  ) UUT (
    .clk(clk),
    .rst_n(rst_n),
    .pause(pause),
    .tdc_intb(tdc_intb),
    .tdc_dout(tdc_dout),
    .tdc_start_signal(tdc_start_signal),
    .tdc_cs(tdc_cs),
    .tdc_sck(tdc_sck),
    .tdc_mosi(tdc_mosi),
    .serial_out(serial_out)
  );

  lidar_monitor #(
    .BAUD_DIV(BAUD_DIV),
    .FIFO_DEPTH(2 ** FIFO_AW),
    .N_ROWS(N_ROWS)
  ) monitor (
    .clk(clk),
    .rst_n(rst_n),
    .pause(pause),
    .tdc_start_signal(tdc_start_signal),
    .tdc_cs(tdc_cs),
    .tdc_sck(tdc_sck),
    .tdc_mosi(tdc_mosi),
    .serial_out(serial_out),
    .exp_results(exp_results),
    .shots(shots),
    .frames(frames),
    .errors(errors)
  );

  bind lidar_top lidar_sva sva (
    .clk(clk),
    .rst_n(rst_n),
    .tdc_start_signal(tdc_start_signal),
    .tdc_cs(tdc_cs),
    .tdc_sck(tdc_sck),
    .serial_out(serial_out)
  );

  // 32-bit fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // n edges, each followed by the drive offset
  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #10;
    end
  endtask

  task automatic build_table();
    logic [31:0] lfsr;
    lfsr = 32'hbfd4_d830;
    for (int i = 0; i < N_ROWS; i++) begin
      // one lfsr step per result bit
      for (int b = 0; b < 24; b++) begin
        lfsr = lfsr_next(lfsr);
        rows[i].result[b] = lfsr[0];
      end
      rows[i].delay  = 8'(3 + (i * 7) % 19);
      // long unpaused run in between so the fifo fills up
      rows[i].pause  = (i == 3) || (i == 14);
      exp_results[i] = rows[i].result;
    end
  endtask

  // tdc model for one shot
  task automatic serve_shot(input stim_row_t row);
    logic [31:0] word;
    // 8 don't-care bits under the opcode, then the result
    word = {8'h00, row.result};
    while (tdc_start_signal !== 1'b1) begin
      wait_cycles(1);
    end
    wait_cycles(int'(row.delay));
    tdc_intb = 1'b0;
    while (tdc_cs !== 1'b0) begin
      wait_cycles(1);
    end
    // new bit after each falling sck, msb first
    for (int k = 31; k >= 0; k--) begin
      tdc_dout = word[k];
      @(negedge tdc_sck);
      #10;
    end
    // last falling sck is also the cs rise
    tdc_intb = 1'b1;
    tdc_dout = 1'b0;
  endtask

  // shot, spi, frame and delay per row, doubled, plus the pauses
  function automatic int watchdog_cycles();
    int max_delay;
    int paused;
    max_delay = 0;
    paused    = 0;
    for (int i = 0; i < N_ROWS; i++) begin
      if (int'(rows[i].delay) > max_delay) begin
        max_delay = int'(rows[i].delay);
      end
      if (rows[i].pause) begin
        paused++;
      end
    end
    return 2 * N_ROWS * (SHOT_PERIOD + 64 * SPI_DIV + 40 * BAUD_DIV + max_delay)
           + paused * PAUSE_CYCLES;
  endfunction

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    rst_n    = 1'b1;
    pause    = 1'b0;
    tdc_intb = 1'b1;
    tdc_dout = 1'b0;
    build_table();
    // clean falling edge for the async reset
    #10;
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #10;
    rst_n = 1'b1;
    for (int i = 0; i < N_ROWS; i++) begin
      if (rows[i].pause) begin
        pause = 1'b1;
        wait_cycles(PAUSE_CYCLES);
        pause = 1'b0;
      end
      serve_shot(rows[i]);
    end
    // queue drains at uart pace
    while (frames < N_ROWS) begin
      wait_cycles(1);
    end
    wait_cycles(10);
    $display("shots %0d, frames %0d, errors %0d, assertion failures %0d",
             shots, frames, errors, UUT.sva.failures);
    if (errors == 0 && UUT.sva.failures == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // watchdog starts once the table is built
  initial begin
    #1;
    repeat (watchdog_cycles()) @(posedge clk);
    $display("watchdog expired after %0d cycles with %0d of %0d frames received",
             watchdog_cycles(), frames, N_ROWS);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire
